//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dual_helix_soc_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o sim
	@out="$$(./$(OBJDIR)/sim)"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJDIR)

//--- build.f
hdl/dhs_bus_pkg.sv
hdl/dhs_map_pkg.sv
hdl/dhs_bus_if.sv
hdl/soc_ram.sv
hdl/periph_regs.sv
hdl/core_link.sv
hdl/system_link.sv
hdl/dual_helix_soc.sv
dv/core_link_asserts.sv
dv/dual_helix_soc_tb.sv

//--- dv/core_link_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module core_link_asserts
  import dhs_bus_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_i,
  input logic [DHS_NUM_MST-1:0] obi_req_i,
  input logic [DHS_NUM_MST-1:0] obi_gnt_o,
  input logic [DHS_NUM_MST-1:0] obi_rvalid_o
);

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (obi_gnt_o & ~obi_req_i) == '0) else $error("gnt to a port without req");

  // Only arbitration holds a request back so some port is granted each cycle
  one_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(obi_gnt_o) && ((|obi_req_i) == (|obi_gnt_o)))
    else $error("gnt count does not match the requests in a cycle");

  for (genvar p = 0; p < DHS_NUM_MST; p++) begin : g_port
    rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
      obi_rvalid_o[p] |-> $past(obi_gnt_o[p])) else $error("rvalid without gnt");
  end

endmodule

bind core_link core_link_asserts u_core_link_asserts (.*);

`default_nettype wire

//--- dv/dual_helix_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dual_helix_soc_tb
  import dhs_bus_pkg::*;
  import dhs_map_pkg::*;
();

  localparam int TIMEOUT = 2000;  // Cycles per traffic run

  typedef struct packed {
    logic [DHS_ADDRW-1:0] addr;
    logic                 we;
    logic [DHS_STRBW-1:0] be;
    logic [DHS_DATAW-1:0] wdata;
  } req_t;

  typedef struct {
    logic [DHS_DATAW-1:0] rdata;
    logic                 err;
    logic                 chk;  // Read data is compared
    int                   cyc;  // Cycle of the grant
  } exp_t;

  logic                                  clk_i;
  logic                                  rst_i;
  logic [DHS_NUM_MST-1:0]                obi_req_i;
  logic [DHS_NUM_MST-1:0][DHS_ADDRW-1:0] obi_addr_i;
  logic [DHS_NUM_MST-1:0]                obi_we_i;
  logic [DHS_NUM_MST-1:0][DHS_STRBW-1:0] obi_be_i;
  logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_wdata_i;
  logic [DHS_NUM_MST-1:0]                obi_gnt_o;
  logic [DHS_NUM_MST-1:0]                obi_rvalid_o;
  logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_rdata_o;
  logic [DHS_NUM_MST-1:0]                obi_err_o;

  integer     seed = 32'h7430_5a50;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         cycle = 0;
  logic [7:0] ram_m [DHS_RAM_WORDS*4];  // Byte model of the RAM
  logic [7:0] reg_m [16];               // Byte model of the peripheral block
  req_t       pend_q [DHS_NUM_MST][$];  // Requests not yet granted
  exp_t       exp_q [DHS_NUM_MST][$];   // Responses in grant order

  dual_helix_soc dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_data(input string name, input logic [DHS_DATAW-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    $display("test %s finished with %0d errors", name, errors - start_err);
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] ram_addr(input int w);
    return {DHS_RAM_REGION, w[13:0], 2'b00};
  endfunction

  function automatic logic [31:0] periph_addr(input int r);
    return {DHS_PERIPH_REGION, 12'h000, r[1:0], 2'b00};
  endfunction

  task automatic queue_req(input int p, input logic [31:0] addr, input logic we,
                           input logic [3:0] be, input logic [31:0] wdata);
    pend_q[p].push_back('{addr: addr, we: we, be: be, wdata: wdata});
  endtask

  task automatic queue_random(input int p);
    logic [31:0] r;
    logic [31:0] bad;
    r   = rnd();
    bad = rnd();
    case (r[2:0])
      3'd0:    queue_req(p, periph_addr(int'(r[5:4])), r[8], r[15:12], rnd());
      3'd1:    queue_req(p, {16'h8000 | bad[31:16], bad[15:0]}, r[8], r[15:12], rnd());
      default: queue_req(p, ram_addr(int'(r[21:16])), r[8], r[15:12], rnd());
    endcase
  endtask

  task automatic queue_readback();
    for (int w = 0; w < 64; w++) queue_req(w % 4, ram_addr(w), 1'b0, 4'hF, '0);
    for (int r = 0; r < 4; r++) queue_req(r, periph_addr(r), 1'b0, 4'hF, '0);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic model_grant(input int p, input req_t r);
    exp_t e;
    int   base;
    e = '{rdata: '0, err: 1'b0, chk: !r.we, cyc: cycle};
    if (r.addr[31:16] == DHS_RAM_REGION && r.addr[15:0] < DHS_RAM_BYTES) begin
      base = int'(r.addr[15:2]) * 4;
      for (int b = 0; b < 4; b++) begin
        e.rdata[8*b +: 8] = ram_m[base + b];  // Old word before the write
        if (r.we && r.be[b]) ram_m[base + b] = r.wdata[8*b +: 8];
      end
    end else if (r.addr[31:16] == DHS_PERIPH_REGION && r.addr[15:0] < DHS_PERIPH_BYTES) begin
      base = int'(r.addr[3:2]) * 4;
      for (int b = 0; b < 4; b++) begin
        e.rdata[8*b +: 8] = reg_m[base + b];
        if (r.we && r.be[b] && base != 0) reg_m[base + b] = r.wdata[8*b +: 8];
      end
      if (base == 0) e.rdata = DHS_SOC_ID;
    end else begin
      e.err = 1'b1;
      e.chk = 1'b1;  // Zero data even for a write
    end
    exp_q[p].push_back(e);
  endtask

  // Drives after the rising edge and samples at the falling edge
  task automatic run_traffic(input string name);
    exp_t e;
    int   guard;
    int   lost [DHS_NUM_MST];  // Grants lost in a row while requesting
    guard = 0;
    for (int p = 0; p < DHS_NUM_MST; p++) begin
      lost[p] = 0;
    end
    while (pend_q[0].size() + pend_q[1].size() + pend_q[2].size() + pend_q[3].size() +
           exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() > 0) begin
      @(posedge clk_i);
      #1;
      for (int p = 0; p < DHS_NUM_MST; p++) begin
        obi_req_i[p] = pend_q[p].size() > 0;
        if (pend_q[p].size() > 0) begin
          obi_addr_i[p]  = pend_q[p][0].addr;
          obi_we_i[p]    = pend_q[p][0].we;
          obi_be_i[p]    = pend_q[p][0].be;
          obi_wdata_i[p] = pend_q[p][0].wdata;
        end
      end
      @(negedge clk_i);
      cycle++;
      for (int p = 0; p < DHS_NUM_MST; p++) begin
        if (obi_rvalid_o[p]) begin
          if (exp_q[p].size() == 0 || exp_q[p][0].cyc != cycle - 1) begin
            $display("port %0d gave rvalid without a gnt in the cycle before", p);
            errors++;
          end else begin
            e = exp_q[p].pop_front();
            check_flag($sformatf("obi_err_o[%0d]", p), obi_err_o[p], e.err);
            if (e.chk) check_data($sformatf("obi_rdata_o[%0d]", p), obi_rdata_o[p], e.rdata);
          end
        end else if (exp_q[p].size() > 0 && exp_q[p][0].cyc < cycle) begin
          $display("port %0d got no rvalid one cycle after its gnt", p);
          errors++;
          void'(exp_q[p].pop_front());
        end
        if (obi_gnt_o[p] && pend_q[p].size() > 0) model_grant(p, pend_q[p].pop_front());
        // Round robin passes a waiting port over at most three times
        if (obi_gnt_o[p]) begin
          lost[p] = 0;
        end else if (obi_req_i[p] && |obi_gnt_o) begin
          lost[p]++;
          if (lost[p] == DHS_NUM_MST) begin
            $display("port %0d was passed over %0d times while requesting", p, lost[p]);
            errors++;
          end
        end
      end
      guard++;
      if (guard > TIMEOUT) begin
        $display("%s timed out with requests or responses still outstanding", name);
        errors++;
        for (int p = 0; p < DHS_NUM_MST; p++) begin
          pend_q[p].delete();
          exp_q[p].delete();
        end
      end
    end
    @(posedge clk_i);
    #1 obi_req_i = '0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int start;
    rst_i       = 1'b1;
    obi_req_i   = '0;
    obi_addr_i  = '0;
    obi_we_i    = '0;
    obi_be_i    = '0;
    obi_wdata_i = '0;
    for (int i = 0; i < 16; i++) reg_m[i] = 8'h00;  // Scratch resets to zero
    repeat (4) @(posedge clk_i);
    #1 rst_i = 1'b0;

    start = errors;
    repeat (5) begin
      @(negedge clk_i);
      check_flag("obi_gnt_o", |obi_gnt_o, 1'b0);
      check_flag("obi_rvalid_o", |obi_rvalid_o, 1'b0);
    end
    report_test("reset", start);

    start = errors;
    for (int w = 0; w < 64; w++) queue_req(w % 4, ram_addr(w), 1'b1, 4'hF, rnd());
    run_traffic("ram_write");
    for (int w = 0; w < 64; w++) queue_req(int'(rnd() & 3), ram_addr(w), 1'b0, 4'hF, '0);
    run_traffic("ram_read");
    report_test("ram_readback", start);

    start = errors;
    for (int i = 0; i < 64; i++) queue_req(i % 4, ram_addr(int'(rnd() & 63)), 1'b1,
                                           4'(rnd()), rnd());
    run_traffic("byte_write");
    queue_readback();
    run_traffic("byte_read");
    report_test("byte_enable", start);

    start = errors;
    for (int r = 0; r < 4; r++) queue_req(1, periph_addr(r), 1'b0, 4'hF, '0);
    run_traffic("reg_reset");
    for (int r = 0; r < 4; r++) queue_req(3, periph_addr(r), 1'b1, 4'hF, rnd());
    for (int r = 0; r < 4; r++) queue_req(3, periph_addr(r), 1'b0, 4'hF, '0);
    run_traffic("reg_rw");
    report_test("periph_regs", start);

    start = errors;
    for (int i = 0; i < 12; i++) begin
      queue_req(i % 4, {16'h8000 | 16'(rnd()), 16'(rnd())}, 1'b1, 4'hF, rnd());
      queue_req(i % 4, {DHS_RAM_REGION, 16'h0400 + 16'(rnd() & 32'h7FFC)}, 1'b1, 4'hF, rnd());
      queue_req(i % 4, {DHS_PERIPH_REGION, 16'h0010 + 16'(rnd() & 32'h0FFC)}, 1'b1,
                4'hF, rnd());
    end
    run_traffic("unmapped");
    queue_readback();
    run_traffic("unmapped_chk");
    report_test("unmapped", start);

    start = errors;
    for (int i = 0; i < 32; i++) begin
      for (int p = 0; p < DHS_NUM_MST; p++) queue_random(p);
    end
    run_traffic("contention");
    queue_readback();
    run_traffic("contention_chk");
    report_test("contention", start);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/core_link.sv
`timescale 1ns/1ps
`default_nettype none

module core_link
  import dhs_bus_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  input  logic [DHS_NUM_MST-1:0]                obi_req_i,
  input  logic [DHS_NUM_MST-1:0][DHS_ADDRW-1:0] obi_addr_i,
  input  logic [DHS_NUM_MST-1:0]                obi_we_i,
  input  logic [DHS_NUM_MST-1:0][DHS_STRBW-1:0] obi_be_i,
  input  logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_wdata_i,
  output logic [DHS_NUM_MST-1:0]                obi_gnt_o,
  output logic [DHS_NUM_MST-1:0]                obi_rvalid_o,
  output logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_rdata_o,
  output logic [DHS_NUM_MST-1:0]                obi_err_o,

  dhs_bus_if.initiator                          bus_o
);

  dhs_mst_id_t rr_ptr_q;   // Port with the highest priority
  dhs_mst_id_t arb_id;     // Round-robin winner this cycle
  dhs_mst_id_t sel_id;     // Port shown on the bus
  logic        lock_q;     // Last request stalled, keep the same port
  dhs_mst_id_t lock_id_q;
  logic        xfer;

  ////////////////////
  // Arbitration
  ////////////////////

  // Scan from the lowest priority up so the first requester after rr_ptr_q wins
  always_comb begin
    arb_id = rr_ptr_q;
    for (int k = DHS_NUM_MST - 1; k >= 0; k--) begin
      if (obi_req_i[rr_ptr_q + dhs_mst_id_t'(k)]) begin
        arb_id = rr_ptr_q + dhs_mst_id_t'(k);
      end
    end
  end

  // A stalled request must stay stable until it is taken
  assign sel_id = lock_q ? lock_id_q : arb_id;
  assign xfer   = bus_o.req_valid & bus_o.req_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr_q  <= '0;
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else begin
      if (xfer) begin
        rr_ptr_q <= sel_id + 1'b1;  // Winner drops to last place
      end
      lock_q    <= bus_o.req_valid & ~bus_o.req_ready;
      lock_id_q <= sel_id;
    end
  end

  ////////////////////
  // Request to bus
  ////////////////////

  assign bus_o.req_valid = |obi_req_i;
  assign bus_o.addr.raw  = obi_addr_i[sel_id];
  assign bus_o.we        = obi_we_i[sel_id];
  assign bus_o.be        = obi_be_i[sel_id];
  assign bus_o.wdata     = obi_wdata_i[sel_id];
  assign bus_o.id        = sel_id;

  always_comb begin
    obi_gnt_o         = '0;
    obi_gnt_o[sel_id] = xfer;  // Same cycle as the transfer
  end

  ////////////////////
  // Response return
  ////////////////////

  always_comb begin
    obi_rvalid_o               = '0;
    obi_err_o                  = '0;
    obi_rvalid_o[bus_o.rsp_id] = bus_o.rsp_valid;
    obi_err_o[bus_o.rsp_id]    = bus_o.rsp_valid & bus_o.rsp_err;
  end

  // Read data fans out, only the port with rvalid samples it
  assign obi_rdata_o = {DHS_NUM_MST{bus_o.rsp_rdata}};

endmodule

`default_nettype wire

//--- hdl/dhs_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dhs_bus_if
  import dhs_bus_pkg::*;
();

  // Request channel
  logic                 req_valid;
  logic                 req_ready;
  dhs_addr_u            addr;
  logic                 we;
  logic [DHS_STRBW-1:0] be;
  logic [DHS_DATAW-1:0] wdata;
  dhs_mst_id_t          id;     // Issuing OBI port

  // Response channel, always accepted
  logic                 rsp_valid;
  logic [DHS_DATAW-1:0] rsp_rdata;
  logic                 rsp_err;
  dhs_mst_id_t          rsp_id;  // Echo of the request id

  modport initiator (
    output req_valid, addr, we, be, wdata, id,
    input  req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_id
  );

  modport target (
    input  req_valid, addr, we, be, wdata, id,
    output req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_id
  );

endinterface

`default_nettype wire

//--- hdl/dhs_bus_pkg.sv
`default_nettype none

package dhs_bus_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int DHS_ADDRW   = 32;
  localparam int DHS_DATAW   = 32;
  localparam int DHS_STRBW   = DHS_DATAW / 8;  // One enable per byte lane
  localparam int DHS_NUM_MST = 4;              // Two cores, instr and data each

  // Which OBI port issued a request
  typedef logic [1:0] dhs_mst_id_t;

  ////////////////////
  // Address word
  ////////////////////

  // The links forward the raw word; only the system link needs region and offset
  typedef union packed {
    logic [DHS_ADDRW-1:0] raw;
    struct packed {
      logic [DHS_ADDRW/2-1:0] region;  // Selects the target
      logic [DHS_ADDRW/2-1:0] offset;  // Byte offset inside the target
    } fields;
  } dhs_addr_u;

endpackage

`default_nettype wire

//--- hdl/dhs_map_pkg.sv
`default_nettype none

package dhs_map_pkg;

  ////////////////////
  // SoC RAM
  ////////////////////

  localparam logic [15:0] DHS_RAM_REGION = 16'h4000;
  localparam logic [15:0] DHS_RAM_BYTES  = 16'd1024;
  localparam int          DHS_RAM_WORDS  = int'(DHS_RAM_BYTES) / 4;  // 256 words

  ////////////////////
  // Peripheral block
  ////////////////////

  localparam logic [15:0] DHS_PERIPH_REGION = 16'h1A10;
  localparam logic [15:0] DHS_PERIPH_BYTES  = 16'd16;  // Four 32-bit registers

  // Register byte offsets inside the peripheral block
  localparam logic [15:0] DHS_REG_ID_OFS = 16'h0000;  // Read-only SoC id

  // Value returned by the id register
  localparam logic [31:0] DHS_SOC_ID = 32'hD4E1_1C5A;

endpackage

`default_nettype wire

//--- hdl/dual_helix_soc.sv
`timescale 1ns/1ps
`default_nettype none

module dual_helix_soc
  import dhs_bus_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  // Ports 0/1 are core 1 instr/data, ports 2/3 are core 2 instr/data
  input  logic [DHS_NUM_MST-1:0]                obi_req_i,
  input  logic [DHS_NUM_MST-1:0][DHS_ADDRW-1:0] obi_addr_i,
  input  logic [DHS_NUM_MST-1:0]                obi_we_i,
  input  logic [DHS_NUM_MST-1:0][DHS_STRBW-1:0] obi_be_i,
  input  logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_wdata_i,
  output logic [DHS_NUM_MST-1:0]                obi_gnt_o,
  output logic [DHS_NUM_MST-1:0]                obi_rvalid_o,
  output logic [DHS_NUM_MST-1:0][DHS_DATAW-1:0] obi_rdata_o,
  output logic [DHS_NUM_MST-1:0]                obi_err_o
);

  dhs_bus_if sys_bus ();  // Core link to system link

  core_link u_core_link (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .obi_req_i    (obi_req_i),
    .obi_addr_i   (obi_addr_i),
    .obi_we_i     (obi_we_i),
    .obi_be_i     (obi_be_i),
    .obi_wdata_i  (obi_wdata_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_rdata_o  (obi_rdata_o),
    .obi_err_o    (obi_err_o),
    .bus_o        (sys_bus)
  );

  system_link u_system_link (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus_i (sys_bus)
  );

endmodule

`default_nettype wire

//--- hdl/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs
  import dhs_bus_pkg::*;
  import dhs_map_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 sel_i,
  input  logic                 we_i,
  input  logic [DHS_STRBW-1:0] be_i,
  input  logic [1:0]           reg_i,
  input  logic [DHS_DATAW-1:0] wdata_i,
  output logic [DHS_DATAW-1:0] rdata_o
);

  logic [DHS_DATAW-1:0] scratch_q [1:3];
  logic                 is_id;

  assign is_id = (reg_i == DHS_REG_ID_OFS[3:2]);

  ////////////////////
  // Scratch registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 1; r <= 3; r++) begin
        scratch_q[r] <= '0;
      end
    end else if (sel_i && we_i && !is_id) begin  // Id register drops writes
      for (int b = 0; b < DHS_STRBW; b++) begin
        if (be_i[b]) begin
          scratch_q[reg_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read, same latency as the RAM
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (is_id) begin
        rdata_o <= DHS_SOC_ID;
      end else begin
        rdata_o <= scratch_q[reg_i];  // Old value on a write
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/soc_ram.sv
`timescale 1ns/1ps
`default_nettype none

module soc_ram
  import dhs_bus_pkg::*;
  import dhs_map_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 sel_i,
  input  logic                 we_i,
  input  logic [DHS_STRBW-1:0] be_i,
  input  logic [7:0]           word_i,
  input  logic [DHS_DATAW-1:0] wdata_i,
  output logic [DHS_DATAW-1:0] rdata_o
);

  logic [DHS_DATAW-1:0] mem_q [DHS_RAM_WORDS];

  // Read before write, a write access returns the old word
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= mem_q[word_i];
      if (we_i) begin
        for (int b = 0; b < DHS_STRBW; b++) begin
          if (be_i[b]) begin
            mem_q[word_i][8*b +: 8] <= wdata_i[8*b +: 8];  // Only enabled lanes
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/system_link.sv
`timescale 1ns/1ps
`default_nettype none

module system_link
  import dhs_bus_pkg::*;
  import dhs_map_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  dhs_bus_if.target bus_i
);

  logic                 xfer;
  logic                 hit_ram;
  logic                 hit_periph;
  logic [DHS_DATAW-1:0] ram_rdata;
  logic [DHS_DATAW-1:0] periph_rdata;

  logic                 rsp_valid_q;
  dhs_mst_id_t          rsp_id_q;
  logic                 rsp_err_q;
  logic                 rsp_ram_q;  // Else the peripheral block answered

  // The response register empties every cycle, so a request is never held off
  assign bus_i.req_ready = 1'b1;
  assign xfer            = bus_i.req_valid & bus_i.req_ready;

  ////////////////////
  // Address decode
  ////////////////////

  assign hit_ram    = (bus_i.addr.fields.region == DHS_RAM_REGION) &&
                      (bus_i.addr.fields.offset < DHS_RAM_BYTES);
  assign hit_periph = (bus_i.addr.fields.region == DHS_PERIPH_REGION) &&
                      (bus_i.addr.fields.offset < DHS_PERIPH_BYTES);

  soc_ram u_soc_ram (
    .clk_i   (clk_i),
    .sel_i   (xfer & hit_ram),
    .we_i    (bus_i.we),
    .be_i    (bus_i.be),
    .word_i  (bus_i.addr.fields.offset[9:2]),
    .wdata_i (bus_i.wdata),
    .rdata_o (ram_rdata)
  );

  periph_regs u_periph_regs (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .sel_i   (xfer & hit_periph),
    .we_i    (bus_i.we),
    .be_i    (bus_i.be),
    .reg_i   (bus_i.addr.fields.offset[3:2]),
    .wdata_i (bus_i.wdata),
    .rdata_o (periph_rdata)
  );

  ////////////////////
  // Response stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= xfer;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rsp_id_q  <= bus_i.id;
      rsp_err_q <= ~(hit_ram | hit_periph);  // Unmapped or out of range
      rsp_ram_q <= hit_ram;
    end
  end

  assign bus_i.rsp_valid = rsp_valid_q;
  assign bus_i.rsp_id    = rsp_id_q;
  assign bus_i.rsp_err   = rsp_err_q;
  assign bus_i.rsp_rdata = rsp_err_q ? '0 : (rsp_ram_q ? ram_rdata : periph_rdata);

endmodule

`default_nettype wire
